/* Makefile */
# Verilator build and run for the Cb 8x8 DCT testbench

VERILATOR ?= verilator
TOP       ?= cb_dct_tb
RTL_TOP   ?= cb_dct
FILELIST  ?= project.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --assert --timing

SOURCES := $(shell grep -v '^+' $(FILELIST))

.PHONY: all build run lint clean

all: run

build: $(BUILD_DIR)/V$(TOP)

$(BUILD_DIR)/V$(TOP): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

run: build
	./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@grep -q "Result: PASSED" $(LOG)

lint:
	$(VERILATOR) --lint-only --timing --top-module $(RTL_TOP) \
		verilog/dct_pkg.sv verilog/dct_row_stage.sv verilog/dct_col_stage.sv verilog/cb_dct.sv
	$(VERILATOR) --lint-only --timing --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* project.f */
verilog/dct_pkg.sv
verilog/dct_row_stage.sv
verilog/dct_col_stage.sv
verilog/cb_dct.sv
verification/cb_dct_tb.sv

/* verification/cb_dct_tb.sv */
module cb_dct_tb;

	timeunit 1ns;
	timeprecision 100ps;

	import dct_pkg::*;

	localparam string STIM_FILE = "verification/dct_stim.txt";
	localparam int MAX_TESTS = 32;
	localparam int BLOCK_PIX = N * N;
	localparam int DRIVE_DELAY = 2;
	localparam int ABORT_PIXELS = 30;
	localparam int OE_DELAY = 7;
	localparam int TIMEOUT_MARGIN = 100;
	localparam logic [31:0] SEED = 32'ha56b7d80;

	logic                        clk;
	logic                        rst;
	logic                        enable;
	logic [PIXEL_W-1:0]          pixel;
	logic [N*N*COEF_W-1:0]       coef;
	logic                        output_enable;

	string test_name [MAX_TESTS];
	string test_cmd [MAX_TESTS];
	int    pix_mem [MAX_TESTS][BLOCK_PIX];
	int    exp_mem [MAX_TESTS][BLOCK_PIX];
	int    num_tests;

	// Blocks sent and not yet checked, with the cycle their pulse is due
	int idx_q [$];
	int due_q [$];

	int          cyc = 0;
	int          cycle_limit = 0;
	int          pass_count = 0;
	int          fail_count = 0;
	int          other_errors = 0;
	bit          first_block_seen = 0;
	bit          reset_err_seen = 0;
	logic [31:0] lcg_state;

	cb_dct i_dut (
		.clk           (clk),
		.rst           (rst),
		.enable        (enable),
		.pixel         (pixel),
		.coef          (coef),
		.output_enable (output_enable)
	);

	initial clk = 1'b0;
	always #20 clk = ~clk;

	always @(posedge clk) begin
		cyc <= cyc + 1;
	end

	function automatic logic [31:0] next_rand();
		lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
		return lcg_state;
	endfunction

	function automatic int coef_at(int i);
		logic signed [COEF_W-1:0] v;
		v = coef[i*COEF_W +: COEF_W];
		return int'(v);
	endfunction

	task automatic finish_run();
		$display("Tests passed: %0d, failed: %0d, other errors: %0d",
			pass_count, fail_count, other_errors);
		if (fail_count == 0 && other_errors == 0)
			$display("Result: PASSED");
		else
			$display("Result: FAILED");
		$finish;
	endtask

	// A word starting with # skips the rest of its line
	// Each test carries 64 pixels and 64 coefficients
	task automatic read_stim(output bit ok);
		int    fd;
		int    code;
		string word;
		string line;
		ok = 1;
		num_tests = 0;
		fd = $fopen(STIM_FILE, "r");
		if (fd == 0) begin
			$display("Could not open the stimulus file %s", STIM_FILE);
			ok = 0;
		end else begin
			while (!$feof(fd) && ok) begin
				code = $fscanf(fd, "%s", word);
				if (code != 1)
					break;
				if (word.substr(0, 0) == "#") begin
					code = $fgets(line, fd);
				end else if (num_tests == MAX_TESTS) begin
					$display("The stimulus file holds more tests than the testbench can store");
					ok = 0;
				end else begin
					test_name[num_tests] = word;
					code = $fscanf(fd, "%s", word);
					test_cmd[num_tests] = word;
					for (int i = 0; i < BLOCK_PIX; i++) begin
						code = $fscanf(fd, "%h", pix_mem[num_tests][i]);
						if (code != 1)
							ok = 0;
					end
					for (int i = 0; i < BLOCK_PIX; i++) begin
						code = $fscanf(fd, "%d", exp_mem[num_tests][i]);
						if (code != 1)
							ok = 0;
					end
					if (!ok)
						$display("The stimulus file is cut short in test %s",
							test_name[num_tests]);
					num_tests++;
				end
			end
			$fclose(fd);
		end
	endtask

	task automatic send_pixels(int t, int count);
		for (int i = 0; i < count; i++) begin
			@(posedge clk);
			#DRIVE_DELAY;
			enable = 1'b1;
			pixel = PIXEL_W'(pix_mem[t][i]);
		end
	endtask

	task automatic idle(int cycles);
		for (int i = 0; i < cycles; i++) begin
			@(posedge clk);
			#DRIVE_DELAY;
			enable = 1'b0;
			pixel = '0;
		end
	endtask

	// Last pixel is sampled one edge after it is driven, the pulse follows 6 edges later
	task automatic send_block(int t);
		send_pixels(t, BLOCK_PIX);
		idx_q.push_back(t);
		due_q.push_back(cyc + OE_DELAY);
	endtask

	task automatic run_test(int t);
		int gap;
		gap = int'(next_rand() >> 16) % 8 + 1;
		if (test_cmd[t] == "block") begin
			send_block(t);
		end else if (test_cmd[t] == "gap") begin
			idle(gap);
			send_block(t);
		end else if (test_cmd[t] == "abort") begin
			send_pixels(t, ABORT_PIXELS);
			idle(gap);
			send_block(t);
		end else begin
			$display("Test %s has an unknown command %s", test_name[t], test_cmd[t]);
			other_errors++;
		end
	endtask

	task automatic check_result();
		int t;
		int due;
		int errs;
		if (idx_q.size() == 0) begin
			$display("output_enable pulsed at cycle %0d with no complete block sent", cyc);
			other_errors++;
		end else begin
			t = idx_q.pop_front();
			due = due_q.pop_front();
			errs = 0;
			if (cyc != due) begin
				$display("Error: %s output_enable cycle expected %0d actual %0d",
					test_name[t], due, cyc);
				errs++;
			end
			for (int i = 0; i < BLOCK_PIX; i++) begin
				if (coef_at(i) != exp_mem[t][i]) begin
					$display("Error: %s coef[%0d] expected %0d actual %0d",
						test_name[t], i, exp_mem[t][i], coef_at(i));
					errs++;
				end
			end
			if (errs == 0) begin
				pass_count++;
				$display("%s: passed", test_name[t]);
			end else begin
				fail_count++;
				$display("%s: failed with %0d mismatches", test_name[t], errs);
			end
		end
		first_block_seen = 1;
	endtask

	// Each output_enable pulse is checked, and coef must stay at its reset value before the first
	always @(negedge clk) begin
		if (!rst) begin
			if (output_enable) begin
				check_result();
			end else if (!first_block_seen && !reset_err_seen) begin
				if (coef != '0) begin
					$display("coef is not zero after reset before the first block");
					reset_err_seen = 1;
					other_errors++;
				end
			end
		end
	end

	always @(posedge clk) begin
		if (cycle_limit > 0 && cyc >= cycle_limit) begin
			$display("Timeout: the run did not finish within %0d cycles", cycle_limit);
			other_errors++;
			finish_run();
		end
	end

	initial begin
		bit ok;
		int blocks;
		rst = 1'b1;
		enable = 1'b0;
		pixel = '0;
		lcg_state = SEED;
		read_stim(ok);
		if (!ok) begin
			other_errors++;
			finish_run();
		end else begin
			blocks = 0;
			for (int t = 0; t < num_tests; t++)
				blocks += (test_cmd[t] == "abort") ? 2 : 1;
			cycle_limit = BLOCK_PIX * blocks + 8 * num_tests + TIMEOUT_MARGIN;
			repeat (2) @(posedge clk);
			#DRIVE_DELAY;
			rst = 1'b0;
			for (int t = 0; t < num_tests; t++)
				run_test(t);
			idle(1);
			while (idx_q.size() != 0)
				@(posedge clk);
			// A few more cycles so that a stray pulse is still caught
			repeat (8) @(posedge clk);
			finish_run();
		end
	end

endmodule

/* verification/dct_stim.txt */
# Each test: name, command (block, gap, abort), 8 rows of 8 hex pixels,
# then 8 rows of expected signed coefficients, row u holds v = 0..7
uniform_128 block
80 80 80 80 80 80 80 80
80 80 80 80 80 80 80 80
80 80 80 80 80 80 80 80
80 80 80 80 80 80 80 80
80 80 80 80 80 80 80 80
80 80 80 80 80 80 80 80
80 80 80 80 80 80 80 80
80 80 80 80 80 80 80 80
0 0 0 0 0 0 0 0
0 0 0 0 0 0 0 0
0 0 0 0 0 0 0 0
0 0 0 0 0 0 0 0
0 0 0 0 0 0 0 0
0 0 0 0 0 0 0 0
0 0 0 0 0 0 0 0
0 0 0 0 0 0 0 0
uniform_255 block
FF FF FF FF FF FF FF FF
FF FF FF FF FF FF FF FF
FF FF FF FF FF FF FF FF
FF FF FF FF FF FF FF FF
FF FF FF FF FF FF FF FF
FF FF FF FF FF FF FF FF
FF FF FF FF FF FF FF FF
FF FF FF FF FF FF FF FF
1015 0 0 0 0 0 0 0
0 0 0 0 0 0 0 0
0 0 0 0 0 0 0 0
0 0 0 0 0 0 0 0
0 0 0 0 0 0 0 0
0 0 0 0 0 0 0 0
0 0 0 0 0 0 0 0
0 0 0 0 0 0 0 0
horizontal_ramp block
00 20 40 60 80 A0 C0 E0
00 20 40 60 80 A0 C0 E0
00 20 40 60 80 A0 C0 E0
00 20 40 60 80 A0 C0 E0
00 20 40 60 80 A0 C0 E0
00 20 40 60 80 A0 C0 E0
00 20 40 60 80 A0 C0 E0
00 20 40 60 80 A0 C0 E0
-127 -583 0 -62 0 -17 0 -6
0 0 0 0 0 0 0 0
0 0 0 0 0 0 0 0
0 0 0 0 0 0 0 0
0 0 0 0 0 0 0 0
0 0 0 0 0 0 0 0
0 0 0 0 0 0 0 0
0 0 0 0 0 0 0 0
vertical_ramp block
00 00 00 00 00 00 00 00
20 20 20 20 20 20 20 20
40 40 40 40 40 40 40 40
60 60 60 60 60 60 60 60
80 80 80 80 80 80 80 80
A0 A0 A0 A0 A0 A0 A0 A0
C0 C0 C0 C0 C0 C0 C0 C0
E0 E0 E0 E0 E0 E0 E0 E0
-128 0 0 0 0 0 0 0
-584 0 0 0 0 0 0 0
0 0 0 0 0 0 0 0
-61 0 0 0 0 0 0 0
0 0 0 0 0 0 0 0
-18 0 0 0 0 0 0 0
1 0 0 0 0 0 0 0
-4 0 0 0 0 0 0 0
checkerboard block
00 FF 00 FF 00 FF 00 FF
FF 00 FF 00 FF 00 FF 00
00 FF 00 FF 00 FF 00 FF
FF 00 FF 00 FF 00 FF 00
00 FF 00 FF 00 FF 00 FF
FF 00 FF 00 FF 00 FF 00
00 FF 00 FF 00 FF 00 FF
FF 00 FF 00 FF 00 FF 00
-3 0 0 0 0 0 0 0
0 -33 0 -39 0 -59 0 -167
0 0 0 0 0 0 0 0
0 -39 0 -46 0 -69 0 -197
0 0 0 0 0 0 0 0
0 -59 0 -69 0 -104 0 -294
0 0 0 0 0 0 0 0
0 -167 0 -197 0 -295 0 -838
back_to_back block
00 20 40 60 80 A0 C0 E0
00 20 40 60 80 A0 C0 E0
00 20 40 60 80 A0 C0 E0
00 20 40 60 80 A0 C0 E0
00 20 40 60 80 A0 C0 E0
00 20 40 60 80 A0 C0 E0
00 20 40 60 80 A0 C0 E0
00 20 40 60 80 A0 C0 E0
-127 -583 0 -62 0 -17 0 -6
0 0 0 0 0 0 0 0
0 0 0 0 0 0 0 0
0 0 0 0 0 0 0 0
0 0 0 0 0 0 0 0
0 0 0 0 0 0 0 0
0 0 0 0 0 0 0 0
0 0 0 0 0 0 0 0
after_gap gap
00 00 00 00 00 00 00 00
20 20 20 20 20 20 20 20
40 40 40 40 40 40 40 40
60 60 60 60 60 60 60 60
80 80 80 80 80 80 80 80
A0 A0 A0 A0 A0 A0 A0 A0
C0 C0 C0 C0 C0 C0 C0 C0
E0 E0 E0 E0 E0 E0 E0 E0
-128 0 0 0 0 0 0 0
-584 0 0 0 0 0 0 0
0 0 0 0 0 0 0 0
-61 0 0 0 0 0 0 0
0 0 0 0 0 0 0 0
-18 0 0 0 0 0 0 0
1 0 0 0 0 0 0 0
-4 0 0 0 0 0 0 0
abort_then_full abort
00 FF 00 FF 00 FF 00 FF
FF 00 FF 00 FF 00 FF 00
00 FF 00 FF 00 FF 00 FF
FF 00 FF 00 FF 00 FF 00
00 FF 00 FF 00 FF 00 FF
FF 00 FF 00 FF 00 FF 00
00 FF 00 FF 00 FF 00 FF
FF 00 FF 00 FF 00 FF 00
-3 0 0 0 0 0 0 0
0 -33 0 -39 0 -59 0 -167
0 0 0 0 0 0 0 0
0 -39 0 -46 0 -69 0 -197
0 0 0 0 0 0 0 0
0 -59 0 -69 0 -104 0 -294
0 0 0 0 0 0 0 0
0 -167 0 -197 0 -295 0 -838

/* verilog/cb_dct.sv */
module cb_dct (
	input  logic                                            clk,
	input  logic                                            rst,
	input  logic                                            enable,
	input  logic [dct_pkg::PIXEL_W-1:0]                     pixel,
	output logic [dct_pkg::N*dct_pkg::N*dct_pkg::COEF_W-1:0] coef,
	output logic                                            output_enable
);

	import dct_pkg::*;

	// One transformed row vector, frequency 0 in the low bits
	logic [N*COEF_W-1:0] row_coef;
	logic                row_valid;

	dct_row_stage i_row_stage (
		.clk       (clk),
		.rst       (rst),
		.enable    (enable),
		.pixel     (pixel),
		.row_coef  (row_coef),
		.row_valid (row_valid)
	);

	// Enable goes here as well so a broken-off block does not leave rows counted
	dct_col_stage i_col_stage (
		.clk           (clk),
		.rst           (rst),
		.enable        (enable),
		.row_coef      (row_coef),
		.row_valid     (row_valid),
		.coef          (coef),
		.output_enable (output_enable)
	);

endmodule

/* verilog/dct_col_stage.sv */
module dct_col_stage (
	input  logic                                            clk,
	input  logic                                            rst,
	input  logic                                            enable,
	input  logic [dct_pkg::N*dct_pkg::COEF_W-1:0]           row_coef,
	input  logic                                            row_valid,
	output logic [dct_pkg::N*dct_pkg::N*dct_pkg::COEF_W-1:0] coef,
	output logic                                            output_enable
);

	import dct_pkg::*;

	logic [ROW_LAT-1:0]      en_dly;
	logic                    en_row;
	logic [N_LOG-1:0]        row_cnt;

	logic signed [COEF_W-1:0] row_val [N];

	logic signed [ACC_W-1:0] prod [N][N];
	logic [N_LOG-1:0]        prod_row;
	logic                    prod_valid;

	logic signed [ACC_W-1:0] acc [N][N];
	logic                    acc_last;

	// Enable delayed to line up with the row results. A row that was finished
	// before enable dropped is still counted, and the count clears after it
	always_ff @(posedge clk) begin
		if (rst)
			en_dly <= '0;
		else
			en_dly <= {en_dly[ROW_LAT-2:0], enable};
	end

	assign en_row = en_dly[ROW_LAT-1];

	always_ff @(posedge clk) begin
		if (rst)
			row_cnt <= '0;
		else if (!en_row)
			row_cnt <= '0;
		else if (row_valid)
			row_cnt <= row_cnt + N_LOG'(1);
	end

	always_comb begin
		for (int v = 0; v < N; v++)
			row_val[v] = row_coef[v*COEF_W +: COEF_W];
	end

	always_ff @(posedge clk) begin
		if (rst)
			prod_valid <= 1'b0;
		else
			prod_valid <= row_valid;
	end

	// Transposed matrix: row r of the block weighs frequency u by entry (u, r)
	always_ff @(posedge clk) begin
		prod_row <= row_cnt;
		for (int u = 0; u < N; u++) begin
			for (int v = 0; v < N; v++)
				prod[u][v] <= ACC_W'(row_val[v]) * DCT_TABLE[u][row_cnt];
		end
	end

	always_ff @(posedge clk) begin
		if (prod_valid) begin
			for (int u = 0; u < N; u++) begin
				for (int v = 0; v < N; v++) begin
					if (prod_row == '0)
						acc[u][v] <= prod[u][v];
					else
						acc[u][v] <= acc[u][v] + prod[u][v];
				end
			end
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			acc_last <= 1'b0;
			output_enable <= 1'b0;
		end else begin
			acc_last <= prod_valid && (prod_row == N_LOG'(N - 1));
			output_enable <= acc_last;
		end
	end

	// Coefficients hold until the next block completes
	always_ff @(posedge clk) begin
		if (rst) begin
			coef <= '0;
		end else if (acc_last) begin
			for (int u = 0; u < N; u++) begin
				for (int v = 0; v < N; v++)
					coef[(u*N + v)*COEF_W +: COEF_W] <= round_coef(acc[u][v]);
			end
		end
	end

	a_oe_single: assert property (
		@(posedge clk) disable iff (rst) output_enable |=> !output_enable
	);

	// The pulse belongs to a block whose eighth row has just wrapped the count
	a_oe_on_wrap: assert property (
		@(posedge clk) disable iff (rst) output_enable |-> row_cnt == '0
	);

endmodule

/* verilog/dct_pkg.sv */
package dct_pkg;

	localparam int PIXEL_W = 8;
	localparam int COEF_W = 11;
	localparam int ACC_W = 25;
	localparam int FRAC_BITS = 14;

	localparam int N = 8;
	localparam int N_LOG = 3;

	// Edges from sampling the last pixel of a row until the column stage takes its result
	localparam int ROW_LAT = 4;

	// Cosine terms scaled by 2^14, C4 is 1/sqrt(8)
	localparam logic signed [ACC_W-1:0] C1 = ACC_W'(8035);
	localparam logic signed [ACC_W-1:0] C2 = ACC_W'(7568);
	localparam logic signed [ACC_W-1:0] C3 = ACC_W'(6811);
	localparam logic signed [ACC_W-1:0] C4 = ACC_W'(5793);
	localparam logic signed [ACC_W-1:0] C5 = ACC_W'(4551);
	localparam logic signed [ACC_W-1:0] C6 = ACC_W'(3135);
	localparam logic signed [ACC_W-1:0] C7 = ACC_W'(1598);

	// Row index is the frequency k, column index the sample n
	localparam logic signed [ACC_W-1:0] DCT_TABLE [N][N] = '{
		'{ C4,  C4,  C4,  C4,  C4,  C4,  C4,  C4},
		'{ C1,  C3,  C5,  C7, -C7, -C5, -C3, -C1},
		'{ C2,  C6, -C6, -C2, -C2, -C6,  C6,  C2},
		'{ C3, -C7, -C1, -C5,  C5,  C1,  C7, -C3},
		'{ C4, -C4, -C4,  C4,  C4, -C4, -C4,  C4},
		'{ C5, -C1,  C7,  C3, -C3, -C7,  C1, -C5},
		'{ C6, -C2,  C2, -C6, -C6,  C2, -C2,  C6},
		'{ C7, -C5,  C3, -C1,  C1, -C3,  C5, -C7}
	};

	// Pixels are not level shifted on input. The DC sum of a row carries
	// 128 * 8 * C4 too much, which is taken off once per row
	localparam logic signed [ACC_W-1:0] DC_OFFSET = ACC_W'(5932032);

	// Drop the fraction and round half up on the first fraction bit
	function automatic logic signed [COEF_W-1:0] round_coef(
		input logic signed [ACC_W-1:0] acc
	);
		return acc[ACC_W-1:FRAC_BITS] + COEF_W'(acc[FRAC_BITS-1]);
	endfunction

endpackage

/* verilog/dct_row_stage.sv */
module dct_row_stage (
	input  logic                                  clk,
	input  logic                                  rst,
	input  logic                                  enable,
	input  logic [dct_pkg::PIXEL_W-1:0]           pixel,
	output logic [dct_pkg::N*dct_pkg::COEF_W-1:0] row_coef,
	output logic                                  row_valid
);

	import dct_pkg::*;

	logic [N_LOG-1:0]        col_cnt;

	logic [PIXEL_W-1:0]      pix_q;
	logic [N_LOG-1:0]        pix_col;
	logic                    pix_valid;

	logic signed [ACC_W-1:0] prod [N];
	logic [N_LOG-1:0]        prod_col;
	logic                    prod_valid;

	logic signed [ACC_W-1:0] acc [N];
	logic                    acc_done;

	// A low enable breaks off the row, the next pixel starts again at column 0
	always_ff @(posedge clk) begin
		if (rst) begin
			col_cnt <= '0;
			pix_valid <= 1'b0;
		end else begin
			pix_valid <= enable;
			if (enable)
				col_cnt <= col_cnt + N_LOG'(1);
			else
				col_cnt <= '0;
		end
	end

	always_ff @(posedge clk) begin
		pix_q <= pixel;
		pix_col <= col_cnt;
	end

	always_ff @(posedge clk) begin
		if (rst)
			prod_valid <= 1'b0;
		else
			prod_valid <= pix_valid;
	end

	// One product per frequency, using the matrix column of this pixel
	always_ff @(posedge clk) begin
		prod_col <= pix_col;
		for (int k = 0; k < N; k++)
			prod[k] <= ACC_W'($signed({1'b0, pix_q})) * DCT_TABLE[k][pix_col];
	end

	// The first pixel of a row loads the sums, so no row leaks into the next
	always_ff @(posedge clk) begin
		for (int k = 0; k < N; k++) begin
			if (!prod_valid)
				acc[k] <= '0;
			else if (prod_col == '0)
				acc[k] <= prod[k];
			else
				acc[k] <= acc[k] + prod[k];
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			acc_done <= 1'b0;
			row_valid <= 1'b0;
		end else begin
			acc_done <= prod_valid && (prod_col == N_LOG'(N - 1));
			row_valid <= acc_done;
		end
	end

	// Only the DC sum needs the level shift correction
	always_ff @(posedge clk) begin
		if (acc_done) begin
			row_coef[0 +: COEF_W] <= round_coef(acc[0] - DC_OFFSET);
			for (int k = 1; k < N; k++)
				row_coef[k*COEF_W +: COEF_W] <= round_coef(acc[k]);
		end
	end

	// Rows are at least 8 pixels apart, so the strobe can never stretch
	a_row_valid_single: assert property (
		@(posedge clk) disable iff (rst) row_valid |=> !row_valid
	);

endmodule
